//--- common/am_params.svh
`ifndef AM_PARAMS_SVH
`define AM_PARAMS_SVH

// one 64b/66b coded block, sync header included.
`define AM_NB_CODED_BLOCK 66

// lanes in the link, one marker per lane.
`define AM_N_ALIGNER 20
`define AM_NB_LANE_ID 5

// valid blocks from marker to marker, marker included.
`define AM_PERIOD 10
`define AM_NB_PERIOD 4

// lock thresholds, quasi static.
`define AM_NB_INV_THR 3
`define AM_NB_VAL_THR 5

`define AM_NB_ERROR_COUNTER 64

`endif

//--- common/am_block_pkg.sv
`default_nettype none

`include "am_params.svh"

package am_block_pkg;

        typedef logic [`AM_NB_CODED_BLOCK-1:0] coded_block_t;
        typedef logic [`AM_NB_LANE_ID-1:0]     lane_id_t;

        typedef enum logic [1:0]
        {
                SH_DATA = 2'b01,
                SH_CTRL = 2'b10
        } sync_header_e;

        typedef struct packed
        {
                logic         valid;
                coded_block_t data;
        } pcs_block_s;

        // M0 M1 M2 of each lane, M0 in the top byte.
        localparam logic [23:0] am_table [`AM_N_ALIGNER] = '{
                24'hc1_68_21, 24'h9d_71_8e, 24'h59_4b_e8, 24'h4d_95_7b,
                24'hf5_07_09, 24'hdd_14_c2, 24'h9a_4a_26, 24'h7b_45_66,
                24'ha0_24_76, 24'h68_c9_fb, 24'hfd_6c_99, 24'hb9_91_55,
                24'h5c_b9_b2, 24'h1a_f8_bd, 24'h83_c7_ca, 24'h35_36_cd,
                24'hc4_31_4c, 24'had_d6_b7, 24'h5f_66_2a, 24'hc0_f0_e5
        };

        // full marker block, bip bytes carried as zero.
        function automatic coded_block_t am_of_lane(input lane_id_t lane);
                logic [23:0] m;
                if (lane < `AM_N_ALIGNER)
                begin
                        m = am_table[lane];
                end
                else
                begin
                        m = am_table[0];  // lanes past the table fall back to lane 0.
                end
                return {SH_CTRL, m, 8'h00, ~m, 8'h00};
        endfunction

endpackage

`default_nettype wire

//--- common/am_lock_pkg.sv
`default_nettype none

package am_lock_pkg;

        import am_block_pkg::*;

        typedef enum logic [1:0]
        {
                LOCK_SEARCH = 2'd0,
                LOCK_COUNT  = 2'd1,
                LOCK_LOCKED = 2'd2
        } lock_state_e;

        // registered result of the marker compare.
        typedef struct packed
        {
                logic         valid;
                logic         hit;
                lane_id_t     lane;
                coded_block_t data;
        } am_match_s;

        typedef struct packed
        {
                logic     am_lock;
                lane_id_t lane_id;
                logic     resync;         // one cycle pulse.
                logic     start_of_lane;  // with the block of a good marker.
        } am_status_s;

endpackage

`default_nettype wire

//--- logic/am_scheduler.sv
`default_nettype none

`include "am_params.svh"

module am_scheduler
        import am_block_pkg::*;
(
        input  wire        tb_clock,
        input  wire        i_arst_n,
        input  wire        i_am_enable,
        input  wire pcs_block_s i_block,
        output pcs_block_s o_block,
        output logic       o_am_slot
);

        localparam logic [`AM_NB_PERIOD-1:0] LAST_SLOT = `AM_PERIOD - 1;

        logic [`AM_NB_PERIOD-1:0] period_cnt;
        logic                     blk_valid_q;
        coded_block_t             blk_data_q;

        always_ff @(posedge tb_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        period_cnt  <= '0;
                        blk_valid_q <= 1'b0;
                        o_am_slot   <= 1'b0;
                end
                else
                begin
                        blk_valid_q <= i_block.valid;
                        o_am_slot   <= i_block.valid && i_am_enable && (period_cnt == '0);
                        if (i_block.valid)
                        begin
                                // the period keeps running with insertion off.
                                period_cnt <= (period_cnt == LAST_SLOT) ? '0 : period_cnt + 1'b1;
                        end
                end
        end

        always_ff @(posedge tb_clock)
        begin
                blk_data_q <= i_block.data;
        end

        assign o_block = '{valid: blk_valid_q, data: blk_data_q};

endmodule

`default_nettype wire

//--- am_insert/am_insertion.sv
`default_nettype none

module am_insertion
        import am_block_pkg::*;
(
        input  wire        tb_clock,
        input  wire        i_arst_n,
        input  wire pcs_block_s i_block,
        input  wire        i_am_slot,
        input  wire lane_id_t i_lane_sel,
        output pcs_block_s o_block
);

        logic         blk_valid_q;
        coded_block_t blk_data_q;
        coded_block_t marker;

        assign marker = am_of_lane(i_lane_sel);

        always_ff @(posedge tb_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        blk_valid_q <= 1'b0;
                end
                else
                begin
                        blk_valid_q <= i_block.valid;
                end
        end

        // the slot flag is only raised on a valid block.
        always_ff @(posedge tb_clock)
        begin
                if (i_am_slot)
                begin
                        blk_data_q <= marker;
                end
                else
                begin
                        blk_data_q <= i_block.data;
                end
        end

        assign o_block = '{valid: blk_valid_q, data: blk_data_q};

endmodule

`default_nettype wire

//--- am_lock/am_lane_match.sv
`default_nettype none

`include "am_params.svh"

module am_lane_match
        import am_block_pkg::*;
        import am_lock_pkg::*;
(
        input  wire        tb_clock,
        input  wire        i_arst_n,
        input  wire pcs_block_s i_block,
        output am_match_s  o_match
);

        logic [`AM_N_ALIGNER-1:0] lane_hit;
        lane_id_t                 lane_enc;

        logic                     valid_q;
        logic                     hit_q;
        lane_id_t                 lane_q;
        coded_block_t             data_q;

        always_comb
        begin
                for (int i = 0; i < `AM_N_ALIGNER; i++)
                begin
                        lane_hit[i] = (i_block.data == am_of_lane(lane_id_t'(i)));
                end
        end

        // markers are distinct, so at most one bit of lane_hit is set.
        always_comb
        begin
                lane_enc = '0;
                for (int i = 0; i < `AM_N_ALIGNER; i++)
                begin
                        if (lane_hit[i])
                        begin
                                lane_enc = lane_enc | lane_id_t'(i);
                        end
                end
        end

        always_ff @(posedge tb_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        valid_q <= 1'b0;
                        hit_q   <= 1'b0;
                end
                else
                begin
                        valid_q <= i_block.valid;
                        hit_q   <= i_block.valid && (|lane_hit);
                end
        end

        always_ff @(posedge tb_clock)
        begin
                lane_q <= lane_enc;
                data_q <= i_block.data;
        end

        assign o_match = '{valid: valid_q, hit: hit_q, lane: lane_q, data: data_q};

endmodule

`default_nettype wire

//--- am_lock/am_lock_fsm.sv
`default_nettype none

`include "am_params.svh"

module am_lock_fsm
        import am_block_pkg::*;
        import am_lock_pkg::*;
(
        input  wire        tb_clock,
        input  wire        i_arst_n,
        input  wire        i_block_lock,
        input  wire [`AM_NB_VAL_THR-1:0] i_valid_am_thr,
        input  wire [`AM_NB_INV_THR-1:0] i_invalid_am_thr,
        input  wire am_match_s i_match,
        output pcs_block_s o_block,
        output am_status_s o_status,
        output logic [`AM_NB_ERROR_COUNTER-1:0] o_error_counter
);

        localparam logic [`AM_NB_PERIOD-1:0] LAST_SLOT = `AM_PERIOD - 1;

        lock_state_e                     state_q, state_n;
        lane_id_t                        lane_q, lane_n;
        logic [`AM_NB_PERIOD-1:0]        period_q, period_n;
        logic [`AM_NB_VAL_THR-1:0]       val_cnt_q, val_cnt_n;
        logic [`AM_NB_INV_THR-1:0]       inv_cnt_q, inv_cnt_n;
        logic [`AM_NB_ERROR_COUNTER-1:0] err_n;
        logic                            resync_n;
        logic                            sol_n;
        logic                            am_slot;
        logic                            good_am;

        logic                            blk_valid_q;
        coded_block_t                    blk_data_q;

        assign am_slot = i_match.valid && (period_q == '0);       // expected marker position.
        assign good_am = i_match.hit && (i_match.lane == lane_q);

        always_comb
        begin
                state_n   = state_q;
                lane_n    = lane_q;
                period_n  = period_q;
                val_cnt_n = val_cnt_q;
                inv_cnt_n = inv_cnt_q;
                err_n     = o_error_counter;
                resync_n  = 1'b0;
                sol_n     = 1'b0;

                if (!i_block_lock)
                begin
                        state_n   = LOCK_SEARCH;
                        period_n  = '0;
                        val_cnt_n = '0;
                        inv_cnt_n = '0;
                end
                else
                begin
                        if (state_q != LOCK_SEARCH && i_match.valid)
                        begin
                                period_n = (period_q == LAST_SLOT) ? '0 : period_q + 1'b1;
                        end

                        case (state_q)
                        LOCK_SEARCH:
                        begin
                                // any marker starts the count, the hit block is slot zero.
                                if (i_match.valid && i_match.hit)
                                begin
                                        state_n   = LOCK_COUNT;
                                        lane_n    = i_match.lane;
                                        period_n  = `AM_NB_PERIOD'(1);
                                        val_cnt_n = `AM_NB_VAL_THR'(1);
                                        inv_cnt_n = '0;
                                        sol_n     = 1'b1;
                                end
                        end
                        LOCK_COUNT:
                        begin
                                if (am_slot && good_am)
                                begin
                                        val_cnt_n = val_cnt_q + 1'b1;
                                        sol_n     = 1'b1;
                                        if ((val_cnt_q + 1'b1) >= i_valid_am_thr)
                                        begin
                                                state_n = LOCK_LOCKED;
                                        end
                                end
                                else if (am_slot)
                                begin
                                        state_n   = LOCK_SEARCH;
                                        period_n  = '0;
                                        val_cnt_n = '0;
                                end
                        end
                        LOCK_LOCKED:
                        begin
                                if (am_slot && good_am)
                                begin
                                        inv_cnt_n = '0;
                                        sol_n     = 1'b1;
                                end
                                else if (am_slot)
                                begin
                                        inv_cnt_n = inv_cnt_q + 1'b1;
                                        err_n     = o_error_counter + 1'b1;
                                        if ((inv_cnt_q + 1'b1) >= i_invalid_am_thr)
                                        begin
                                                state_n   = LOCK_SEARCH;
                                                resync_n  = 1'b1;
                                                period_n  = '0;
                                                val_cnt_n = '0;
                                                inv_cnt_n = '0;
                                        end
                                end
                        end
                        default:
                        begin
                                state_n = LOCK_SEARCH;
                        end
                        endcase
                end
        end

        always_ff @(posedge tb_clock or negedge i_arst_n)
        begin
                if (!i_arst_n)
                begin
                        state_q         <= LOCK_SEARCH;
                        lane_q          <= '0;
                        period_q        <= '0;
                        val_cnt_q       <= '0;
                        inv_cnt_q       <= '0;
                        o_error_counter <= '0;
                        o_status        <= '0;
                        blk_valid_q     <= 1'b0;
                end
                else
                begin
                        state_q                <= state_n;
                        lane_q                 <= lane_n;
                        period_q               <= period_n;
                        val_cnt_q              <= val_cnt_n;
                        inv_cnt_q              <= inv_cnt_n;
                        o_error_counter        <= err_n;
                        o_status.am_lock       <= (state_n == LOCK_LOCKED);
                        o_status.lane_id       <= (state_n == LOCK_LOCKED) ? lane_n : '0;
                        o_status.resync        <= resync_n;
                        o_status.start_of_lane <= sol_n;
                        blk_valid_q            <= i_match.valid;
                end
        end

        always_ff @(posedge tb_clock)
        begin
                blk_data_q <= i_match.data;
        end

        assign o_block = '{valid: blk_valid_q, data: blk_data_q};

endmodule

`default_nettype wire

//--- logic/am_link_top.sv
`default_nettype none

`include "am_params.svh"

module am_link_top
        import am_block_pkg::*;
        import am_lock_pkg::*;
(
        input  wire        tb_clock,
        input  wire        i_arst_n,
        input  wire pcs_block_s i_block,
        input  wire        i_am_enable,
        input  wire lane_id_t i_lane_sel,
        input  wire        i_block_lock,
        input  wire [`AM_NB_VAL_THR-1:0] i_valid_am_thr,
        input  wire [`AM_NB_INV_THR-1:0] i_invalid_am_thr,
        output pcs_block_s o_block,
        output am_status_s o_status,
        output logic [`AM_NB_ERROR_COUNTER-1:0] o_error_counter
);

        pcs_block_s sched_block;
        logic       sched_am_slot;
        pcs_block_s tx_block;     // the single lane of the loopback.
        am_match_s  rx_match;

        am_scheduler u_scheduler
        (
                .tb_clock    (tb_clock),
                .i_arst_n    (i_arst_n),
                .i_am_enable (i_am_enable),
                .i_block     (i_block),
                .o_block     (sched_block),
                .o_am_slot   (sched_am_slot)
        );

        am_insertion u_insertion
        (
                .tb_clock   (tb_clock),
                .i_arst_n   (i_arst_n),
                .i_block    (sched_block),
                .i_am_slot  (sched_am_slot),
                .i_lane_sel (i_lane_sel),
                .o_block    (tx_block)
        );

        am_lane_match u_lane_match
        (
                .tb_clock (tb_clock),
                .i_arst_n (i_arst_n),
                .i_block  (tx_block),
                .o_match  (rx_match)
        );

        am_lock_fsm u_lock_fsm
        (
                .tb_clock         (tb_clock),
                .i_arst_n         (i_arst_n),
                .i_block_lock     (i_block_lock),
                .i_valid_am_thr   (i_valid_am_thr),
                .i_invalid_am_thr (i_invalid_am_thr),
                .i_match          (rx_match),
                .o_block          (o_block),
                .o_status         (o_status),
                .o_error_counter  (o_error_counter)
        );

endmodule

`default_nettype wire

//--- tests/tb_am_link.sv
`default_nettype none

`include "am_params.svh"

module tb_am_link
        import am_block_pkg::*;
        import am_lock_pkg::*;
();

        localparam int          VALID_THR   = 5;
        localparam int          INVALID_THR = 3;
        localparam logic [31:0] SEED        = 32'hf63c_0e35;
        localparam lane_id_t    LANE_A      = 5'd4;
        localparam lane_id_t    LANE_B      = 5'd9;

        // expected state of the whole loopback that advances once per rising edge.
        typedef struct packed
        {
                int unsigned                     sched_cnt;
                logic                            sched_slot;
                pcs_block_s                      sched_blk;
                pcs_block_s                      tx_near;  // lane delay line.
                pcs_block_s                      tx_far;
                lock_state_e                     state;
                lane_id_t                        lane;
                int unsigned                     period;
                int unsigned                     val_cnt;
                int unsigned                     inv_cnt;
                logic [`AM_NB_ERROR_COUNTER-1:0] err;
                pcs_block_s                      exp_block;
                am_status_s                      exp_status;
        } ref_state_s;

        logic                            tb_clock = 1'b0;
        logic                            i_arst_n;
        pcs_block_s                      i_block;
        logic                            i_am_enable;
        lane_id_t                        i_lane_sel;
        logic                            i_block_lock;
        logic [`AM_NB_VAL_THR-1:0]       i_valid_am_thr;
        logic [`AM_NB_INV_THR-1:0]       i_invalid_am_thr;
        pcs_block_s                      o_block;
        am_status_s                      o_status;
        logic [`AM_NB_ERROR_COUNTER-1:0] o_error_counter;

        ref_state_s                      mdl;
        logic [31:0]                     lcg_seed;
        logic [31:0]                     word_hi;
        string                           test_name;
        logic [`AM_NB_ERROR_COUNTER-1:0] err_start;
        int                              seen;

        am_link_top dut0
        (
                .tb_clock         (tb_clock),
                .i_arst_n         (i_arst_n),
                .i_block          (i_block),
                .i_am_enable      (i_am_enable),
                .i_lane_sel       (i_lane_sel),
                .i_block_lock     (i_block_lock),
                .i_valid_am_thr   (i_valid_am_thr),
                .i_invalid_am_thr (i_invalid_am_thr),
                .o_block          (o_block),
                .o_status         (o_status),
                .o_error_counter  (o_error_counter)
        );

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        // lane whose marker equals the block or -1 for data.
        function automatic int lane_of_block(input coded_block_t d);
                int lane;
                lane = -1;
                for (int i = 0; i < `AM_N_ALIGNER; i++)
                begin
                        if (d == am_of_lane(lane_id_t'(i)))
                        begin
                                lane = i;
                        end
                end
                return lane;
        endfunction

        function automatic ref_state_s ref_step(input ref_state_s s, input pcs_block_s blk,
                                                input logic en, input lane_id_t sel,
                                                input logic blk_lock, input logic rst_n);
                ref_state_s n;
                pcs_block_s rx;
                int         hit_lane;
                logic       hit;
                logic       slot;
                logic       good;
                n = s;
                if (!rst_n)
                begin
                        n = '0;
                        return n;
                end
                rx       = s.tx_far;
                hit_lane = lane_of_block(rx.data);
                hit      = rx.valid && (hit_lane >= 0);
                slot     = rx.valid && (s.period == 0);
                good     = hit && (lane_id_t'(hit_lane) == s.lane);
                n.exp_block                = rx;
                n.exp_status.resync        = 1'b0;
                n.exp_status.start_of_lane = 1'b0;
                if (!blk_lock)
                begin
                        n.state   = LOCK_SEARCH;
                        n.period  = 0;
                        n.val_cnt = 0;
                        n.inv_cnt = 0;
                end
                else
                begin
                        if (s.state != LOCK_SEARCH && rx.valid)
                        begin
                                n.period = (s.period + 1) % `AM_PERIOD;
                        end
                        case (s.state)
                        LOCK_SEARCH:
                        begin
                                if (hit)
                                begin
                                        n.state   = LOCK_COUNT;
                                        n.lane    = lane_id_t'(hit_lane);
                                        n.period  = 1;  // the hit block is slot zero.
                                        n.val_cnt = 1;
                                        n.inv_cnt = 0;
                                        n.exp_status.start_of_lane = 1'b1;
                                end
                        end
                        LOCK_COUNT:
                        begin
                                if (slot && good)
                                begin
                                        n.val_cnt = s.val_cnt + 1;
                                        n.exp_status.start_of_lane = 1'b1;
                                        if (n.val_cnt >= VALID_THR)
                                        begin
                                                n.state = LOCK_LOCKED;
                                        end
                                end
                                else if (slot)
                                begin
                                        n.state   = LOCK_SEARCH;
                                        n.period  = 0;
                                        n.val_cnt = 0;
                                end
                        end
                        LOCK_LOCKED:
                        begin
                                if (slot && good)
                                begin
                                        n.inv_cnt = 0;
                                        n.exp_status.start_of_lane = 1'b1;
                                end
                                else if (slot)
                                begin
                                        n.inv_cnt = s.inv_cnt + 1;
                                        n.err     = s.err + 1'b1;
                                        if (n.inv_cnt >= INVALID_THR)
                                        begin
                                                n.state             = LOCK_SEARCH;
                                                n.exp_status.resync = 1'b1;
                                                n.period            = 0;
                                                n.val_cnt           = 0;
                                                n.inv_cnt           = 0;
                                        end
                                end
                        end
                        default:
                        begin
                                n.state = LOCK_SEARCH;
                        end
                        endcase
                end
                n.exp_status.am_lock = (n.state == LOCK_LOCKED);
                n.exp_status.lane_id = n.exp_status.am_lock ? n.lane : '0;
                // the lane select is taken when the tx side builds the marker.
                n.tx_far        = s.tx_near;
                n.tx_near.valid = s.sched_blk.valid;
                n.tx_near.data  = s.sched_slot ? am_of_lane(sel) : s.sched_blk.data;
                n.sched_slot    = blk.valid && en && (s.sched_cnt == 0);
                n.sched_blk     = blk;
                if (blk.valid)
                begin
                        n.sched_cnt = (s.sched_cnt + 1) % `AM_PERIOD;
                end
                return n;
        endfunction

        function automatic string fmt_status(input am_status_s st);
                return $sformatf("lock %0b lane %0d resync %0b sol %0b",
                                 st.am_lock, st.lane_id, st.resync, st.start_of_lane);
        endfunction

        task automatic fail_value(input string what, input string exp_s, input string act_s);
                $display("** Error [%s] %s: expected %s, actual %s",
                         test_name, what, exp_s, act_s);
                $display("test failed");
                $fatal(1, "value mismatch");
        endtask

        task automatic check_block(input pcs_block_s exp, input pcs_block_s act);
                if (exp.valid !== act.valid || (exp.valid && exp.data !== act.data))
                begin
                        fail_value("o_block", $sformatf("%0b/%h", exp.valid, exp.data),
                                   $sformatf("%0b/%h", act.valid, act.data));
                end
        endtask

        task automatic check_status(input am_status_s exp, input am_status_s act);
                if (exp !== act)
                begin
                        fail_value("o_status", fmt_status(exp), fmt_status(act));
                end
        endtask

        task automatic check_errors(input logic [`AM_NB_ERROR_COUNTER-1:0] exp,
                                    input logic [`AM_NB_ERROR_COUNTER-1:0] act);
                if (exp !== act)
                begin
                        fail_value("o_error_counter", $sformatf("%0d", exp),
                                   $sformatf("%0d", act));
                end
        endtask

        task automatic check_count(input string what, input int exp, input int act);
                if (exp != act)
                begin
                        fail_value(what, $sformatf("%0d", exp), $sformatf("%0d", act));
                end
        endtask

        task automatic wait_status(input string field, input logic level, input int limit);
                int   n;
                logic hit;
                n   = 0;
                hit = 1'b0;
                while (!hit && n < limit)
                begin
                        @(negedge tb_clock);
                        hit = (field == "resync") ? (o_status.resync == level)
                                                  : (o_status.am_lock == level);
                        n++;
                end
                if (!hit)
                begin
                        $display("[%s] timeout, %s never went to %0b within %0d cycles",
                                 test_name, field, level, limit);
                        $display("test failed");
                        $fatal(1, "wait timeout");
                end
        endtask

        always #50 tb_clock = ~tb_clock;  // period 100.

        // random data blocks that are valid every cycle.
        always @(negedge tb_clock)
        begin
                lcg_seed = lcg_next(lcg_seed);
                word_hi  = lcg_seed;
                lcg_seed = lcg_next(lcg_seed);
                i_block  = '{valid: 1'b1, data: {SH_DATA, word_hi, lcg_seed}};
        end

        always @(posedge tb_clock)
        begin
                mdl = ref_step(mdl, i_block, i_am_enable, i_lane_sel, i_block_lock, i_arst_n);
        end

        always @(negedge tb_clock)
        begin
                check_block(mdl.exp_block, o_block);
                check_status(mdl.exp_status, o_status);
                check_errors(mdl.err, o_error_counter);
        end

        initial
        begin
                i_arst_n         = 1'b0;
                i_block          = '0;
                i_am_enable      = 1'b1;
                i_lane_sel       = LANE_A;
                i_block_lock     = 1'b1;
                i_valid_am_thr   = `AM_NB_VAL_THR'(VALID_THR);
                i_invalid_am_thr = `AM_NB_INV_THR'(INVALID_THR);
                mdl              = '0;
                lcg_seed         = SEED;
                test_name        = "reset";
                repeat (8) @(negedge tb_clock);
                i_arst_n = 1'b1;

                test_name = "transparency";
                repeat (5) @(negedge tb_clock);  // pipeline fill.
                seen = 0;
                repeat (3 * `AM_PERIOD)
                begin
                        @(negedge tb_clock);
                        if (o_block.valid && o_block.data == am_of_lane(LANE_A))
                        begin
                                seen++;
                        end
                end
                check_count("markers at o_block", 3, seen);

                test_name = "lock_acquire";
                wait_status("am_lock", 1'b1, 10 * `AM_PERIOD);
                check_status(am_status_s'{am_lock: 1'b1, lane_id: LANE_A, resync: 1'b0,
                                          start_of_lane: 1'b1}, o_status);
                seen = 0;
                repeat (3 * `AM_PERIOD)
                begin
                        @(negedge tb_clock);
                        if (o_status.start_of_lane)
                        begin
                                seen++;
                        end
                end
                check_count("start_of_lane pulses", 3, seen);

                test_name   = "marker_loss";
                err_start   = o_error_counter;
                i_am_enable = 1'b0;
                wait_status("resync", 1'b1, 6 * `AM_PERIOD);
                check_status(am_status_s'{am_lock: 1'b0, lane_id: '0, resync: 1'b1,
                                          start_of_lane: 1'b0}, o_status);
                check_errors(err_start + INVALID_THR, o_error_counter);
                i_am_enable = 1'b1;
                wait_status("am_lock", 1'b1, 10 * `AM_PERIOD);
                check_status(am_status_s'{am_lock: 1'b1, lane_id: LANE_A, resync: 1'b0,
                                          start_of_lane: 1'b1}, o_status);

                test_name  = "lane_change";
                err_start  = o_error_counter;
                i_lane_sel = LANE_B;
                wait_status("resync", 1'b1, 6 * `AM_PERIOD);
                check_errors(err_start + INVALID_THR, o_error_counter);
                wait_status("am_lock", 1'b1, 10 * `AM_PERIOD);
                check_status(am_status_s'{am_lock: 1'b1, lane_id: LANE_B, resync: 1'b0,
                                          start_of_lane: 1'b1}, o_status);

                test_name    = "block_lock_drop";
                err_start    = o_error_counter;
                i_block_lock = 1'b0;
                wait_status("am_lock", 1'b0, 1);
                check_status('0, o_status);
                repeat (2 * `AM_PERIOD) @(negedge tb_clock);
                i_block_lock = 1'b1;
                wait_status("am_lock", 1'b1, 10 * `AM_PERIOD);
                check_status(am_status_s'{am_lock: 1'b1, lane_id: LANE_B, resync: 1'b0,
                                          start_of_lane: 1'b1}, o_status);
                check_errors(err_start, o_error_counter);

                $display("test passed");
                $finish;
        end

endmodule

`default_nettype wire

//--- am_link.f
+incdir+common
common/am_block_pkg.sv
common/am_lock_pkg.sv
logic/am_scheduler.sv
am_insert/am_insertion.sv
am_lock/am_lane_match.sv
am_lock/am_lock_fsm.sv
logic/am_link_top.sv
tests/tb_am_link.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; the exit status is the result.
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal \
        --top-module tb_am_link \
        -f am_link.f \
        -o sim_am_link &&
./obj_dir/sim_am_link || exit 1
